// File: snoop_cfg.svh
`ifndef SNOOP_CFG_SVH
`define SNOOP_CFG_SVH

// --------------------
// ACE snoop channel widths
// --------------------

// Snoop address on the AC channel
`define ACE_ADDR_W 44

// One CD beat
`define ACE_DATA_W 128

// 64-byte cache line split into CD beats
`define CACHE_BEATS 4
`define LINE_W (`ACE_DATA_W * `CACHE_BEATS)

// --------------------
// Responder settings
// --------------------

// Low address bits checked against the window
`define FILTER_ADDR_W 32

// Replies that may wait for the CR/CD channels
`define REPLY_FIFO_DEPTH 4

// Reply-kind bit value that asks for a data reply
`define DATA_REPLY 1'b1

`endif

// File: snoop_pkg.sv
`include "snoop_cfg.svh"

package snoop_pkg;

    // --------------------
    // Control word
    // --------------------
    typedef struct packed {
        logic                      enable;
        // CR value sent with a data reply
        logic [4:0]                crresp;
        logic                      op_filter_en;
        logic                      addr_filter_en;
        logic                      one_shot;
        logic [3:0]                filter_op;
        // Window is [win_base, win_base + win_size)
        logic [`FILTER_ADDR_W-1:0] win_base;
        logic [`FILTER_ADDR_W-1:0] win_size;
    } snoop_ctrl_t;

    // --------------------
    // Incoming snoop
    // --------------------
    typedef struct packed {
        logic [`ACE_ADDR_W-1:0] addr;
        logic [3:0]             opcode;
        // Controller's choice of data or dummy reply
        logic                   kind;
        logic [`LINE_W-1:0]     line;
    } snoop_req_t;

    // --------------------
    // Decided reply
    // --------------------
    typedef struct packed {
        // Full answer with CD beats
        logic               is_data;
        // Zero for a dummy
        logic [4:0]         crresp;
        logic [`LINE_W-1:0] line;
    } reply_t;

endpackage

// File: snoop_filter.sv
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module snoop_filter
(
    input  logic                   ace_aclk,
    input  logic                   ace_aresetn,
    input  logic                   i_snoop_valid,
    input  snoop_pkg::snoop_req_t  i_snoop,
    input  snoop_pkg::snoop_ctrl_t i_ctrl,
    input  logic                   i_reply_done,
    input  logic                   i_reply_was_data,
    output logic                   o_push_valid,
    output snoop_pkg::reply_t      o_push,
    output logic                   o_end
);

    logic [`FILTER_ADDR_W-1:0] snoop_low;
    logic [`FILTER_ADDR_W:0]   win_end;
    logic                      op_hit;
    logic                      addr_hit;
    logic                      match;

    // --------------------
    // Match rule
    // --------------------
    assign snoop_low = i_snoop.addr[`FILTER_ADDR_W-1:0];

    // One extra bit so a window reaching the top of the space does not wrap
    assign win_end = {1'b0, i_ctrl.win_base} + {1'b0, i_ctrl.win_size};

    assign op_hit = !i_ctrl.op_filter_en || (i_snoop.opcode == i_ctrl.filter_op);

    assign addr_hit = !i_ctrl.addr_filter_en ||
                      ((snoop_low >= i_ctrl.win_base) && ({1'b0, snoop_low} < win_end));

    // Lockout after one-shot also lands here
    assign match = i_ctrl.enable && op_hit && addr_hit && !o_end &&
                   (i_snoop.kind == `DATA_REPLY);

    // --------------------
    // Registered decision
    // --------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
            o_push_valid <= 1'b0;
        else
            o_push_valid <= i_snoop_valid;
    end

    always_ff @(posedge ace_aclk)
    begin
        if (i_snoop_valid)
        begin
            o_push.is_data <= match;
            o_push.crresp  <= match ? i_ctrl.crresp : 5'd0;
            o_push.line    <= i_snoop.line;
        end
    end

    // One-shot end flag, held until the controller drops enable
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
            o_end <= 1'b0;
        else if (!i_ctrl.enable)
            o_end <= 1'b0;
        else if (i_reply_done && i_reply_was_data && i_ctrl.one_shot)
            o_end <= 1'b1;
    end

    // Reply completion arrives as a single-cycle strobe
    assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        i_reply_done |=> !i_reply_done)
        else $error("reply done held for more than one cycle");

endmodule

// File: reply_fifo.sv
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module reply_fifo
(
    input  logic                                    ace_aclk,
    input  logic                                    ace_aresetn,
    input  logic                                    i_push_valid,
    input  snoop_pkg::reply_t                       i_push,
    input  logic                                    i_head_ready,
    output logic                                    o_head_valid,
    output snoop_pkg::reply_t                       o_head,
    output logic [$clog2(`REPLY_FIFO_DEPTH + 1)-1:0] o_count,
    output logic                                    o_overflow
);

    localparam int PTR_W = (`REPLY_FIFO_DEPTH > 1) ? $clog2(`REPLY_FIFO_DEPTH) : 1;

    snoop_pkg::reply_t mem [`REPLY_FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              full;
    logic              wr_en;
    logic              rd_en;

    // Wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`REPLY_FIFO_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign full  = (o_count == `REPLY_FIFO_DEPTH);
    assign wr_en = i_push_valid && !full;
    assign rd_en = i_head_ready && o_head_valid;

    // First word falls through to the responder
    assign o_head_valid = (o_count != '0);
    assign o_head       = mem[rd_ptr];

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            o_count    <= '0;
            o_overflow <= 1'b0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= ptr_inc(wr_ptr);
            if (rd_en)
                rd_ptr <= ptr_inc(rd_ptr);

            case ({wr_en, rd_en})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: o_count <= o_count;
            endcase

            // Sticky until reset
            if (i_push_valid && full)
                o_overflow <= 1'b1;
        end
    end

    // Storage
    always_ff @(posedge ace_aclk)
    begin
        if (wr_en)
            mem[wr_ptr] <= i_push;
    end

    // Responder only pops an entry that is there
    assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        i_head_ready |-> o_head_valid)
        else $error("pop from empty reply FIFO");

endmodule

// File: snoop_responder.sv
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module snoop_responder
(
    input  logic                   ace_aclk,
    input  logic                   ace_aresetn,
    input  logic                   i_head_valid,
    input  snoop_pkg::reply_t      i_head,
    input  logic                   i_crready,
    input  logic                   i_cdready,
    output logic                   o_head_ready,
    output logic                   o_crvalid,
    output logic [4:0]             o_crresp,
    output logic                   o_cdvalid,
    output logic [`ACE_DATA_W-1:0] o_cddata,
    output logic                   o_cdlast,
    output logic                   o_reply_done,
    output logic                   o_reply_was_data,
    output logic                   o_active
);

    localparam int BEAT_W = (`CACHE_BEATS > 1) ? $clog2(`CACHE_BEATS) : 1;
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`CACHE_BEATS - 1);

    // --------------------
    // FSM encoding
    // --------------------
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RESP = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0]        state;
    logic [BEAT_W-1:0] beat;
    snoop_pkg::reply_t cur;

    // Pop straight from idle
    assign o_head_ready = (state == ST_IDLE) && i_head_valid;

    // --------------------
    // CR and CD channels
    // --------------------
    assign o_crvalid = (state == ST_RESP);
    assign o_crresp  = cur.crresp;

    // Lowest beat of the line goes first
    assign o_cdvalid = (state == ST_DATA);
    assign o_cddata  = cur.line[beat * `ACE_DATA_W +: `ACE_DATA_W];
    assign o_cdlast  = o_cdvalid && (beat == LAST_BEAT);

    // Completion report back to the filter
    assign o_reply_done     = (state == ST_DONE);
    assign o_reply_was_data = cur.is_data;
    assign o_active         = (state != ST_IDLE);

    always_ff @(posedge ace_aclk)
    begin
        if (o_head_ready)
            cur <= i_head;
    end

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            state <= ST_IDLE;
            beat  <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    beat <= '0;
                    if (i_head_valid)
                        state <= ST_RESP;
                end
                ST_RESP:
                begin
                    // Dummy reply ends with the CR handshake
                    if (i_crready)
                        state <= cur.is_data ? ST_DATA : ST_DONE;
                end
                ST_DATA:
                begin
                    if (i_cdready)
                    begin
                        if (beat == LAST_BEAT)
                            state <= ST_DONE;
                        else
                            beat <= beat + 1'b1;
                    end
                end
                ST_DONE:
                begin
                    state <= ST_IDLE;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // --------------------
    // ACE hold rules
    // --------------------
    assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        o_cdvalid && !i_cdready |=>
            o_cdvalid && $stable(o_cddata) && $stable(o_cdlast))
        else $error("CD beat changed while stalled");

    assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        o_crvalid && !i_crready |=> o_crvalid && $stable(o_crresp))
        else $error("CR response changed while stalled");

endmodule

// File: passive_snooper_top.sv
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module passive_snooper_top
(
    input  logic                   ace_aclk,
    input  logic                   ace_aresetn,
    input  logic                   i_snoop_valid,
    input  snoop_pkg::snoop_req_t  i_snoop,
    input  snoop_pkg::snoop_ctrl_t i_ctrl,
    input  logic                   i_crready,
    input  logic                   i_cdready,
    output logic                   o_crvalid,
    output logic [4:0]             o_crresp,
    output logic                   o_cdvalid,
    output logic [`ACE_DATA_W-1:0] o_cddata,
    output logic                   o_cdlast,
    output logic                   o_end,
    output logic                   o_overflow,
    output logic                   o_busy
);

    logic                                    push_valid;
    snoop_pkg::reply_t                       push;
    logic                                    head_valid;
    logic                                    head_ready;
    snoop_pkg::reply_t                       head;
    logic [$clog2(`REPLY_FIFO_DEPTH + 1)-1:0] fifo_count;
    logic                                    reply_done;
    logic                                    reply_was_data;
    logic                                    resp_active;

    snoop_filter filter_i (
        .ace_aclk         (ace_aclk),
        .ace_aresetn      (ace_aresetn),
        .i_snoop_valid    (i_snoop_valid),
        .i_snoop          (i_snoop),
        .i_ctrl           (i_ctrl),
        .i_reply_done     (reply_done),
        .i_reply_was_data (reply_was_data),
        .o_push_valid     (push_valid),
        .o_push           (push),
        .o_end            (o_end)
    );

    reply_fifo fifo_i (
        .ace_aclk     (ace_aclk),
        .ace_aresetn  (ace_aresetn),
        .i_push_valid (push_valid),
        .i_push       (push),
        .i_head_ready (head_ready),
        .o_head_valid (head_valid),
        .o_head       (head),
        .o_count      (fifo_count),
        .o_overflow   (o_overflow)
    );

    snoop_responder responder_i (
        .ace_aclk         (ace_aclk),
        .ace_aresetn      (ace_aresetn),
        .i_head_valid     (head_valid),
        .i_head           (head),
        .i_crready        (i_crready),
        .i_cdready        (i_cdready),
        .o_head_ready     (head_ready),
        .o_crvalid        (o_crvalid),
        .o_crresp         (o_crresp),
        .o_cdvalid        (o_cdvalid),
        .o_cddata         (o_cddata),
        .o_cdlast         (o_cdlast),
        .o_reply_done     (reply_done),
        .o_reply_was_data (reply_was_data),
        .o_active         (resp_active)
    );

    // Queued or in flight
    assign o_busy = (fifo_count != '0) || resp_active;

endmodule

// File: tb_passive_snooper.sv
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module tb_passive_snooper;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int W_CRVALID      = 0;
    localparam int W_END          = 1;
    localparam int W_OVERFLOW     = 2;

    logic                   ace_aclk;
    logic                   ace_aresetn;
    logic                   i_snoop_valid;
    snoop_pkg::snoop_req_t  i_snoop;
    snoop_pkg::snoop_ctrl_t i_ctrl;
    logic                   i_crready;
    logic                   i_cdready;
    logic                   o_crvalid;
    logic [4:0]             o_crresp;
    logic                   o_cdvalid;
    logic [`ACE_DATA_W-1:0] o_cddata;
    logic                   o_cdlast;
    logic                   o_end;
    logic                   o_overflow;
    logic                   o_busy;

    integer                 seed        = 32'hbaf9;
    int                     errors      = 0;
    int                     replies     = 0;
    bit                     stall_en    = 1'b0;
    bit                     cr_hold_low = 1'b0;
    bit                     lockout     = 1'b0;
    bit                     cd_pending  = 1'b0;
    int                     beat_no     = 0;
    snoop_pkg::snoop_ctrl_t ctrl_now;
    snoop_pkg::reply_t      cur_exp;
    snoop_pkg::reply_t      exp_q [$];

    passive_snooper_top dut_i (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_snoop_valid (i_snoop_valid),
        .i_snoop       (i_snoop),
        .i_ctrl        (i_ctrl),
        .i_crready     (i_crready),
        .i_cdready     (i_cdready),
        .o_crvalid     (o_crvalid),
        .o_crresp      (o_crresp),
        .o_cdvalid     (o_cdvalid),
        .o_cddata      (o_cddata),
        .o_cdlast      (o_cdlast),
        .o_end         (o_end),
        .o_overflow    (o_overflow),
        .o_busy        (o_busy)
    );

    initial
    begin
        ace_aclk = 1'b0;
        forever #4 ace_aclk = ~ace_aclk;
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic check_val(input logic [`LINE_W-1:0] got, input logic [`LINE_W-1:0] exp,
                             input string msg);
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Closing: %0d errors, %0d replies checked", errors, replies);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("Timeout at %0t: waited too long for %s", $time, what);
        finish_run();
    endtask

    // Expected answer from the match rule
    function automatic snoop_pkg::reply_t expected_reply(input snoop_pkg::snoop_req_t r,
                                                         input snoop_pkg::snoop_ctrl_t c,
                                                         input bit end_flag);
        snoop_pkg::reply_t e;
        longint unsigned   low;
        longint unsigned   hi_bound;
        bit                hit;
        low      = r.addr[`FILTER_ADDR_W-1:0];
        hi_bound = longint'(c.win_base) + longint'(c.win_size);
        hit      = c.enable && !end_flag && (r.kind == `DATA_REPLY);
        if (c.op_filter_en && (r.opcode != c.filter_op))
            hit = 1'b0;
        if (c.addr_filter_en && ((low < c.win_base) || (low >= hi_bound)))
            hit = 1'b0;
        e.is_data = hit;
        e.crresp  = hit ? c.crresp : 5'd0;
        e.line    = r.line;
        return e;
    endfunction

    function automatic logic watched(input int sel);
        case (sel)
            W_CRVALID: return o_crvalid;
            W_END:     return o_end;
            default:   return o_overflow;
        endcase
    endfunction

    task automatic wait_level(input int sel, input logic level, input string what);
        int cycles;
        cycles = 0;
        while ((watched(sel) !== level) && (cycles < TIMEOUT_CYCLES))
        begin
            @(posedge ace_aclk);
            cycles++;
        end
        if (watched(sel) !== level)
            give_up(what);
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || cd_pending || o_busy) && (cycles < TIMEOUT_CYCLES))
        begin
            @(posedge ace_aclk);
            cycles++;
        end
        if (exp_q.size() != 0 || cd_pending || o_busy)
            give_up("the queued replies to drain");
    endtask

    task automatic random_req(input logic kind, output snoop_pkg::snoop_req_t r);
        r.addr   = {12'($random(seed)), 32'($random(seed))};
        r.opcode = 4'($random(seed));
        r.kind   = kind;
        for (int i = 0; i < `LINE_W / 32; i++)
            r.line[i*32 +: 32] = $random(seed);
    endtask

    task automatic set_ctrl(input snoop_pkg::snoop_ctrl_t c);
        @(posedge ace_aclk);
        i_ctrl   <= c;
        ctrl_now = c;
    endtask

    // One strobe cycle, queued in request order
    task automatic send_req(input snoop_pkg::snoop_req_t r, input bit expect_reply);
        @(posedge ace_aclk);
        i_snoop_valid <= 1'b1;
        i_snoop       <= r;
        if (expect_reply)
            exp_q.push_back(expected_reply(r, ctrl_now, lockout));
    endtask

    task automatic end_strobe();
        @(posedge ace_aclk);
        i_snoop_valid <= 1'b0;
    endtask

    task automatic send_group(input int n, input logic kind, input bit mix);
        snoop_pkg::snoop_req_t r;
        int                    sel;
        for (int i = 0; i < n; i++)
        begin
            random_req(kind, r);
            if (mix)
            begin
                sel = $random(seed) & 7;
                if ($random(seed) & 1)
                    r.opcode = ctrl_now.filter_op;
                // Window edges and a spread inside it
                case (sel)
                    0: r.addr[31:0] = ctrl_now.win_base;
                    1: r.addr[31:0] = ctrl_now.win_base + ctrl_now.win_size;
                    2: r.addr[31:0] = ctrl_now.win_base + ctrl_now.win_size - 1;
                    3: r.addr[31:0] = ctrl_now.win_base - 1;
                    4, 5: r.addr[31:0] = ctrl_now.win_base + ($random(seed) & 32'hfff);
                    default: ;
                endcase
            end
            send_req(r, 1'b1);
        end
        end_strobe();
        drain();
    endtask

    // --------------------
    // Ready drivers
    // --------------------
    initial
    begin
        i_crready = 1'b1;
        i_cdready = 1'b1;
        forever
        begin
            @(posedge ace_aclk);
            if (cr_hold_low)
                i_crready <= 1'b0;
            else
                i_crready <= !stall_en || (($random(seed) & 7) != 0);
            i_cdready <= !stall_en || (($random(seed) & 7) != 0);
        end
    end

    // --------------------
    // CR/CD monitor
    // --------------------
    initial
    begin
        forever
        begin
            @(posedge ace_aclk);
            // A reply on the wire means the responder is busy
            if (ace_aresetn && (o_crvalid || o_cdvalid))
                check_val(o_busy, 1'b1, "o_busy while a reply is out");
            if (ace_aresetn && o_crvalid && i_crready)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("CR response at %0t with no request outstanding", $time);
                end
                else
                begin
                    if (cd_pending)
                    begin
                        errors++;
                        $display("CR response at %0t before the previous data burst ended",
                                 $time);
                    end
                    cur_exp = exp_q.pop_front();
                    check_val(o_crresp, cur_exp.crresp, "CR response");
                    cd_pending = cur_exp.is_data;
                    beat_no    = 0;
                    replies++;
                end
            end
            if (ace_aresetn && o_cdvalid && i_cdready)
            begin
                if (!cd_pending)
                begin
                    errors++;
                    $display("CD beat at %0t where no data reply was due", $time);
                end
                else
                begin
                    check_val(o_cddata, cur_exp.line[beat_no*`ACE_DATA_W +: `ACE_DATA_W],
                              $sformatf("CD data beat %0d", beat_no));
                    check_val(o_cdlast, beat_no == `CACHE_BEATS - 1, "CD last flag");
                    if (beat_no == `CACHE_BEATS - 1)
                        cd_pending = 1'b0;
                    beat_no++;
                end
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial
    begin
        snoop_pkg::snoop_ctrl_t c;
        snoop_pkg::snoop_req_t  r;
        ace_aresetn   = 1'b0;
        i_snoop_valid = 1'b0;
        i_snoop       = '0;
        i_ctrl        = '0;
        ctrl_now      = '0;
        repeat (5) @(posedge ace_aclk);
        ace_aresetn <= 1'b1;
        @(posedge ace_aclk);
        check_val({o_crvalid, o_cdvalid, o_cdlast, o_end, o_overflow, o_busy}, 6'b0,
                  "outputs after reset");

        // Filters off, full answers
        c         = '0;
        c.enable  = 1'b1;
        c.crresp  = 5'h0b;
        c.win_base = 32'h4000_0000;
        c.win_size = 32'h0000_1000;
        c.filter_op = 4'h7;
        set_ctrl(c);
        for (int i = 0; i < 4; i++)
            send_group(1, `DATA_REPLY, 1'b0);

        // Opcode, address, then both filters
        for (int m = 1; m < 4; m++)
        begin
            c.op_filter_en   = m[0];
            c.addr_filter_en = m[1];
            set_ctrl(c);
            for (int i = 0; i < 5; i++)
                send_group(3, `DATA_REPLY, 1'b1);
        end

        // Dummy kind, then enable low
        send_group(3, !`DATA_REPLY, 1'b1);
        c.enable = 1'b0;
        set_ctrl(c);
        send_group(3, `DATA_REPLY, 1'b1);

        // Random stalls on both channels
        c.enable = 1'b1;
        set_ctrl(c);
        stall_en = 1'b1;
        for (int i = 0; i < 6; i++)
            send_group(3, `DATA_REPLY, 1'b1);
        stall_en = 1'b0;

        // One-shot lockout
        c.op_filter_en   = 1'b0;
        c.addr_filter_en = 1'b0;
        c.one_shot       = 1'b1;
        set_ctrl(c);
        check_val(o_end, 1'b0, "o_end before first data reply");
        random_req(`DATA_REPLY, r);
        send_req(r, 1'b1);
        end_strobe();
        wait_level(W_END, 1'b1, "o_end to rise");
        check_val(exp_q.size() == 0 && !cd_pending, 1'b1, "o_end only after reply done");
        lockout = 1'b1;
        send_group(3, `DATA_REPLY, 1'b0);
        check_val(o_end, 1'b1, "o_end held while enabled");
        c.enable = 1'b0;
        set_ctrl(c);
        wait_level(W_END, 1'b0, "o_end to fall");
        lockout = 1'b0;

        // Overflow with CR held off
        c.enable   = 1'b1;
        c.one_shot = 1'b0;
        set_ctrl(c);
        check_val(o_overflow, 1'b0, "o_overflow before the flood");
        cr_hold_low = 1'b1;
        random_req(`DATA_REPLY, r);
        send_req(r, 1'b1);
        end_strobe();
        wait_level(W_CRVALID, 1'b1, "the stalled CR response");
        for (int i = 0; i < 5; i++)
        begin
            random_req(`DATA_REPLY, r);
            // Fifth one finds the FIFO full
            send_req(r, i < 4);
        end
        end_strobe();
        wait_level(W_OVERFLOW, 1'b1, "o_overflow to rise");
        cr_hold_low = 1'b0;
        drain();
        check_val(o_overflow, 1'b1, "o_overflow stays set");

        finish_run();
    end

endmodule

// File: all.f
+incdir+.
snoop_pkg.sv
snoop_filter.sv
reply_fifo.sv
snoop_responder.sv
passive_snooper_top.sv
tb_passive_snooper.sv

// File: Bender.yml
package:
  name: passive_snooper

sources:
  - include_dirs:
      - .
    files:
      - snoop_pkg.sv
      - snoop_filter.sv
      - reply_fifo.sv
      - snoop_responder.sv
      - passive_snooper_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_passive_snooper.sv
